// File: pic_pkg.sv
package pic_pkg;

   // Field widths
   localparam int PRIO_W = 4;
   localparam int ID_W   = 8;
   localparam int WORD_W = 32;

   typedef logic [PRIO_W-1:0] prio_t;   // Interrupt priority
   typedef logic [ID_W-1:0]   id_t;     // Source id with 0 reserved
   typedef logic [WORD_W-1:0] word_t;   // Register data and address

   ////////////////////
   // Register map offsets from the PIC base address

   localparam word_t PRIO_OFS   = 32'h0000_0000;   // One word per source
   localparam word_t PEND_OFS   = 32'h0000_1000;   // Read only
   localparam word_t ENABLE_OFS = 32'h0000_2000;
   localparam word_t CONFIG_OFS = 32'h0000_3000;   // Single word
   localparam word_t GWCFG_OFS  = 32'h0000_4000;
   localparam word_t GWCLR_OFS  = 32'h0000_5000;   // Write only

   // Highest level in normal order
   localparam prio_t PRIO_MAX = 4'd15;

endpackage

// File: pic_gateway.sv
`timescale 1ns/1ps

module pic_gateway (
   input  logic clk,
   input  logic rst_n,
   input  logic req,          // Raw request pin
   input  logic polarity,     // 1 for active low
   input  logic level_type,   // Trigger type with 1 for edge
   input  logic clear,        // One-cycle clear from the register file
   output logic pending
);

   logic sync_q1;
   logic sync_q2;
   logic active;
   logic pend_q;

   // Two-flop synchronizer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= req;
         sync_q2 <= sync_q1;
      end
   end

   assign active = sync_q2 ^ polarity;

   // Held until software writes the clear address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_q <= 1'b0;
      end else begin
         pend_q <= active | (pend_q & ~clear);
      end
   end

   assign pending = level_type ? (active | pend_q) : active;

endmodule

// File: pic_regs.sv
`timescale 1ns/1ps

module pic_regs #(
   parameter int             NUM_SRC       = 15,
   parameter pic_pkg::word_t PIC_BASE_ADDR = 32'hF00C_0000
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  pic_pkg::word_t                rd_addr,
   input  pic_pkg::word_t                wr_addr,
   input  pic_pkg::word_t                wr_data,
   input  logic                          wren,
   input  logic                          rden,
   input  logic [NUM_SRC:0]              req_gw,       // Gateway outputs for the pending word
   output pic_pkg::word_t                rd_data,
   output pic_pkg::prio_t [NUM_SRC:0]    prio,
   output logic [NUM_SRC:0]              enable,
   output logic [NUM_SRC:0]              gw_polarity,
   output logic [NUM_SRC:0]              gw_type,
   output logic [NUM_SRC:0]              gw_clear,
   output logic                          reverse       // 1 reverses the priority order
);

   localparam int IDX_W = $clog2(NUM_SRC + 1);
   localparam int HI    = pic_pkg::WORD_W - 1;
   localparam int LO    = IDX_W + 2;   // Lowest bit above the word index

   localparam pic_pkg::word_t PRIO_BASE  = PIC_BASE_ADDR + pic_pkg::PRIO_OFS;
   localparam pic_pkg::word_t PEND_BASE  = PIC_BASE_ADDR + pic_pkg::PEND_OFS;
   localparam pic_pkg::word_t EN_BASE    = PIC_BASE_ADDR + pic_pkg::ENABLE_OFS;
   localparam pic_pkg::word_t CFG_ADDR   = PIC_BASE_ADDR + pic_pkg::CONFIG_OFS;
   localparam pic_pkg::word_t GWCFG_BASE = PIC_BASE_ADDR + pic_pkg::GWCFG_OFS;
   localparam pic_pkg::word_t GWCLR_BASE = PIC_BASE_ADDR + pic_pkg::GWCLR_OFS;

   logic                 wren_q;
   logic                 rden_q;
   pic_pkg::word_t       rd_addr_q;
   pic_pkg::word_t       wr_addr_q;
   pic_pkg::word_t       wr_data_q;
   logic [IDX_W-1:0]     rd_idx;
   logic [IDX_W-1:0]     wr_idx;
   logic [NUM_SRC:0]     rd_sel;
   logic [NUM_SRC:0]     wr_sel;
   logic                 wr_prio_hit, wr_en_hit, wr_gwcfg_hit, wr_gwclr_hit, wr_cfg_hit;
   logic                 rd_prio_hit, rd_en_hit, rd_gwcfg_hit, rd_pend_hit, rd_cfg_hit;
   pic_pkg::prio_t       prio_rd;
   logic                 en_rd;
   logic [1:0]           gwcfg_rd;

   ////////////////////
   // Access port

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= wren;
         rden_q <= rden;
      end
   end

   always_ff @(posedge clk) begin
      rd_addr_q <= rd_addr;
      wr_addr_q <= wr_addr;
      wr_data_q <= wr_data;
   end

   assign rd_idx = rd_addr_q[IDX_W+1:2];
   assign wr_idx = wr_addr_q[IDX_W+1:2];

   // Region decode
   assign wr_prio_hit  = wren_q && (wr_addr_q[HI:LO] == PRIO_BASE[HI:LO]);
   assign wr_en_hit    = wren_q && (wr_addr_q[HI:LO] == EN_BASE[HI:LO]);
   assign wr_gwcfg_hit = wren_q && (wr_addr_q[HI:LO] == GWCFG_BASE[HI:LO]);
   assign wr_gwclr_hit = wren_q && (wr_addr_q[HI:LO] == GWCLR_BASE[HI:LO]);
   assign wr_cfg_hit   = wren_q && (wr_addr_q == CFG_ADDR);

   assign rd_prio_hit  = rden_q && (rd_addr_q[HI:LO] == PRIO_BASE[HI:LO]);
   assign rd_en_hit    = rden_q && (rd_addr_q[HI:LO] == EN_BASE[HI:LO]);
   assign rd_gwcfg_hit = rden_q && (rd_addr_q[HI:LO] == GWCFG_BASE[HI:LO]);
   assign rd_pend_hit  = rden_q && (rd_addr_q == PEND_BASE);   // Word 0 only
   assign rd_cfg_hit   = rden_q && (rd_addr_q == CFG_ADDR);

   // Index decode with id 0 never selected
   always_comb begin
      rd_sel = '0;
      wr_sel = '0;
      for (int i = 1; i <= NUM_SRC; i++) begin
         rd_sel[i] = (rd_idx == IDX_W'(i));
         wr_sel[i] = (wr_idx == IDX_W'(i));
      end
   end

   assign gw_clear = wr_sel & {(NUM_SRC + 1){wr_gwclr_hit}};

   ////////////////////
   // Register file

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prio        <= '0;
         enable      <= '0;
         gw_polarity <= '0;
         gw_type     <= '0;
         reverse     <= 1'b0;
      end else begin
         for (int i = 1; i <= NUM_SRC; i++) begin
            if (wr_prio_hit && wr_sel[i]) begin
               prio[i] <= wr_data_q[pic_pkg::PRIO_W-1:0];
            end
            if (wr_en_hit && wr_sel[i]) begin
               enable[i] <= wr_data_q[0];
            end
            if (wr_gwcfg_hit && wr_sel[i]) begin
               gw_polarity[i] <= wr_data_q[0];
               gw_type[i]     <= wr_data_q[1];
            end
         end
         if (wr_cfg_hit) begin
            reverse <= wr_data_q[0];
         end
      end
   end

   ////////////////////
   // Read mux

   always_comb begin
      prio_rd  = '0;
      en_rd    = 1'b0;
      gwcfg_rd = '0;
      for (int i = 1; i <= NUM_SRC; i++) begin
         prio_rd  |= prio[i] & {pic_pkg::PRIO_W{rd_sel[i]}};
         en_rd    |= enable[i] & rd_sel[i];
         gwcfg_rd |= {gw_type[i], gw_polarity[i]} & {2{rd_sel[i]}};
      end
   end

   assign rd_data = ({pic_pkg::WORD_W{rd_prio_hit}}  & pic_pkg::word_t'(prio_rd))
                  | ({pic_pkg::WORD_W{rd_en_hit}}    & pic_pkg::word_t'(en_rd))
                  | ({pic_pkg::WORD_W{rd_gwcfg_hit}} & pic_pkg::word_t'(gwcfg_rd))
                  | ({pic_pkg::WORD_W{rd_pend_hit}}  & pic_pkg::word_t'(req_gw))
                  | ({pic_pkg::WORD_W{rd_cfg_hit}}   & pic_pkg::word_t'(reverse));

endmodule

// File: pic_arbiter.sv
`timescale 1ns/1ps

module pic_arbiter #(
   parameter int NUM_SRC = 15
) (
   input  pic_pkg::prio_t [NUM_SRC:0] eff_prio,
   output pic_pkg::id_t               sel_id,
   output pic_pkg::prio_t             sel_prio
);

   localparam int LEVELS = $clog2(NUM_SRC + 1);
   localparam int LEAVES = 1 << LEVELS;
   localparam int NODES  = 2 * LEAVES - 1;

   // Tree nodes in heap order with the root at 0 and the leaves at the top indices
   pic_pkg::prio_t node_prio [NODES];
   pic_pkg::id_t   node_id   [NODES];

   ////////////////////
   // Leaves

   for (genvar j = 0; j < LEAVES; j++) begin : g_leaf
      if (j <= NUM_SRC) begin : g_src
         assign node_prio[LEAVES-1+j] = eff_prio[j];
         assign node_id[LEAVES-1+j]   = pic_pkg::id_t'(j);
      end else begin : g_pad
         assign node_prio[LEAVES-1+j] = '0;   // Empty slot never wins
         assign node_id[LEAVES-1+j]   = '0;
      end
   end

   ////////////////////
   // Compare and select

   for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
      logic right_wins;

      // Strict compare so ties stay with the lower id
      assign right_wins   = node_prio[2*n+1] < node_prio[2*n+2];
      assign node_prio[n] = right_wins ? node_prio[2*n+2] : node_prio[2*n+1];
      assign node_id[n]   = right_wins ? node_id[2*n+2]   : node_id[2*n+1];
   end

   assign sel_prio = node_prio[0];
   assign sel_id   = node_id[0];

endmodule

// File: pic_notify.sv
`timescale 1ns/1ps

module pic_notify (
   input  logic           clk,
   input  logic           rst_n,
   input  pic_pkg::id_t   sel_id,      // Winner from the tree
   input  pic_pkg::prio_t sel_prio,    // Effective priority of the winner
   input  logic           reverse,
   input  pic_pkg::prio_t meicurpl,    // Current priority level
   input  pic_pkg::prio_t meipt,       // Priority threshold
   output logic           mexintpend,
   output pic_pkg::id_t   claimid,
   output pic_pkg::prio_t pl,
   output logic           mhwakeup
);

   pic_pkg::prio_t meipt_eff;
   pic_pkg::prio_t curpl_eff;
   pic_pkg::prio_t pl_next;
   pic_pkg::prio_t wake_lvl;
   logic           req_next;

   // Bring thresholds into the same order as the tree
   assign meipt_eff = reverse ? ~meipt    : meipt;
   assign curpl_eff = reverse ? ~meicurpl : meicurpl;

   assign req_next = (sel_prio > meipt_eff) && (sel_prio > curpl_eff);
   assign pl_next  = reverse ? ~sel_prio : sel_prio;   // Back to software order
   assign wake_lvl = reverse ? '0 : pic_pkg::PRIO_MAX;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mexintpend <= 1'b0;
         claimid    <= '0;
         pl         <= '0;
         mhwakeup   <= 1'b0;
      end else begin
         mexintpend <= req_next;
         claimid    <= sel_id;
         pl         <= pl_next;
         mhwakeup   <= (pl_next == wake_lvl);   // Top level request
      end
   end

endmodule

// File: pic_top.sv
`timescale 1ns/1ps

module pic_top #(
   parameter int             NUM_SRC       = 15,
   parameter pic_pkg::word_t PIC_BASE_ADDR = 32'hF00C_0000
) (
   input  logic             clk,
   input  logic             rst_n,
   input  pic_pkg::word_t   rd_addr,
   input  pic_pkg::word_t   wr_addr,
   input  pic_pkg::word_t   wr_data,
   input  logic             wren,
   input  logic             rden,
   input  logic [NUM_SRC:0] extintsrc_req,   // Bit 0 is reserved
   input  pic_pkg::prio_t   meicurpl,
   input  pic_pkg::prio_t   meipt,
   output pic_pkg::word_t   rd_data,
   output logic             mexintpend,
   output pic_pkg::id_t     claimid,
   output pic_pkg::prio_t   pl,
   output logic             mhwakeup
);

   pic_pkg::prio_t [NUM_SRC:0] prio;
   pic_pkg::prio_t [NUM_SRC:0] eff_prio;
   logic [NUM_SRC:0]           enable;
   logic [NUM_SRC:0]           gw_polarity;
   logic [NUM_SRC:0]           gw_type;
   logic [NUM_SRC:0]           gw_clear;
   logic [NUM_SRC:0]           req_gw;
   logic                       reverse;
   pic_pkg::id_t               sel_id;
   pic_pkg::prio_t             sel_prio;

   pic_regs #(
      .NUM_SRC       (NUM_SRC),
      .PIC_BASE_ADDR (PIC_BASE_ADDR)
   ) u_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_addr     (rd_addr),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .wren        (wren),
      .rden        (rden),
      .req_gw      (req_gw),
      .rd_data     (rd_data),
      .prio        (prio),
      .enable      (enable),
      .gw_polarity (gw_polarity),
      .gw_type     (gw_type),
      .gw_clear    (gw_clear),
      .reverse     (reverse)
   );

   ////////////////////
   // Gateways and priority gating

   assign req_gw[0] = 1'b0;   // Id 0 is never pending

   for (genvar i = 1; i <= NUM_SRC; i++) begin : g_src
      pic_gateway u_gw (
         .clk        (clk),
         .rst_n      (rst_n),
         .req        (extintsrc_req[i]),
         .polarity   (gw_polarity[i]),
         .level_type (gw_type[i]),
         .clear      (gw_clear[i]),
         .pending    (req_gw[i])
      );
   end

   for (genvar i = 0; i <= NUM_SRC; i++) begin : g_eff
      assign eff_prio[i] = (enable[i] && req_gw[i]) ? (reverse ? ~prio[i] : prio[i]) : '0;
   end

   pic_arbiter #(
      .NUM_SRC (NUM_SRC)
   ) u_arb (
      .eff_prio (eff_prio),
      .sel_id   (sel_id),
      .sel_prio (sel_prio)
   );

   pic_notify u_notify (
      .clk        (clk),
      .rst_n      (rst_n),
      .sel_id     (sel_id),
      .sel_prio   (sel_prio),
      .reverse    (reverse),
      .meicurpl   (meicurpl),
      .meipt      (meipt),
      .mexintpend (mexintpend),
      .claimid    (claimid),
      .pl         (pl),
      .mhwakeup   (mhwakeup)
   );

endmodule

// File: pic_chk.sv
`timescale 1ns/1ps

module pic_chk (
   input logic           clk,
   input logic           rst_n,
   input logic           rden,
   input pic_pkg::word_t rd_data,
   input logic           mexintpend,
   input pic_pkg::id_t   claimid,
   input pic_pkg::prio_t pl,
   input logic           mhwakeup
);

   // Reset clears every output
   a_reset_zero : assert property (@(posedge clk) !rst_n |=>
      (rd_data == '0 && !mexintpend && claimid == '0 && pl == '0 && !mhwakeup))
      else $error("outputs not zero after a reset cycle");

   a_claim_valid : assert property (@(posedge clk) disable iff (!rst_n)
      mexintpend |-> claimid != '0)
      else $error("interrupt request with claim id 0");

   a_idle_read : assert property (@(posedge clk) disable iff (!rst_n)
      !rden |=> rd_data == '0)
      else $error("read data not zero after a cycle without a read");

endmodule

bind pic_top pic_chk u_chk (
   .clk        (clk),
   .rst_n      (rst_n),
   .rden       (rden),
   .rd_data    (rd_data),
   .mexintpend (mexintpend),
   .claimid    (claimid),
   .pl         (pl),
   .mhwakeup   (mhwakeup)
);

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter realtime PERIOD = 100.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD / 2.0) clk = ~clk;   // Free running

endmodule

// File: tb_pic_monitor.sv
`timescale 1ns/1ps

module tb_pic_monitor #(
   parameter int             NUM_SRC       = 15,
   parameter pic_pkg::word_t PIC_BASE_ADDR = 32'hF00C_0000
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             wren,
   input  pic_pkg::word_t   wr_addr,
   input  pic_pkg::word_t   wr_data,
   input  logic [NUM_SRC:0] extintsrc_req,
   input  pic_pkg::prio_t   meicurpl,
   input  pic_pkg::prio_t   meipt,
   input  pic_pkg::word_t   rd_data,
   input  logic             mexintpend,
   input  pic_pkg::id_t     claimid,
   input  pic_pkg::prio_t   pl,
   input  logic             mhwakeup,
   input  logic             check_rd,     // Read issued this cycle
   input  pic_pkg::word_t   exp_rd,
   input  logic             check_out,    // Start polling the outputs
   input  logic             use_model,    // Expected outputs from the shadow model
   input  pic_pkg::id_t     exp_id,
   input  pic_pkg::prio_t   exp_pl,
   input  logic             exp_int,
   input  logic             exp_wake,
   output int               err_count,
   output int               done_cnt
);

   pic_pkg::prio_t sh_prio [NUM_SRC+1];
   logic           sh_en   [NUM_SRC+1];
   logic           sh_pol  [NUM_SRC+1];
   logic           sh_rev;
   pic_pkg::word_t lat_rd;
   pic_pkg::id_t   want_id;
   pic_pkg::prio_t want_pl;
   logic           want_int;
   logic           want_wake;

   ////////////////////
   // Shadow of the register file taken from the write port

   always @(posedge clk) begin : shadow
      pic_pkg::word_t off;
      int             idx;
      off = wr_addr - PIC_BASE_ADDR;
      idx = int'(off[11:2]);
      if (!rst_n) begin
         for (int i = 0; i <= NUM_SRC; i++) begin
            sh_prio[i] <= '0;
            sh_en[i]   <= 1'b0;
            sh_pol[i]  <= 1'b0;
         end
         sh_rev <= 1'b0;
      end else if (wren) begin
         if (idx >= 1 && idx <= NUM_SRC) begin
            case (off[31:12])
               20'h0:   sh_prio[idx] <= wr_data[3:0];
               20'h2:   sh_en[idx]   <= wr_data[0];
               20'h4:   sh_pol[idx]  <= wr_data[0];
               default: ;
            endcase
         end
         if (off == pic_pkg::CONFIG_OFS) sh_rev <= wr_data[0];
      end
   end

   // Selection rule for level sources only
   task automatic model_outputs();
      pic_pkg::prio_t best;
      pic_pkg::prio_t e;
      pic_pkg::prio_t th;
      pic_pkg::prio_t cur;
      best    = '0;
      want_id = '0;
      for (int i = 1; i <= NUM_SRC; i++) begin
         e = sh_rev ? ~sh_prio[i] : sh_prio[i];
         if (sh_en[i] && (extintsrc_req[i] ^ sh_pol[i]) && e > best) begin
            best    = e;
            want_id = pic_pkg::id_t'(i);
         end
      end
      th        = sh_rev ? ~meipt : meipt;
      cur       = sh_rev ? ~meicurpl : meicurpl;
      want_pl   = sh_rev ? ~best : best;
      want_int  = (best > th) && (best > cur);
      want_wake = (want_pl == (sh_rev ? 4'd0 : 4'd15));
   endtask

   task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
      err_count++;
   endtask

   function automatic logic outputs_match();
      return (claimid === want_id) && (pl === want_pl)
          && (mexintpend === want_int) && (mhwakeup === want_wake);
   endfunction

   task automatic poll_outputs();
      logic hit;
      pic_pkg::id_t   t_id;
      pic_pkg::prio_t t_pl;
      logic           t_int;
      logic           t_wake;
      logic           t_mdl;
      hit    = 1'b0;
      t_id   = exp_id;   // Latched before the testbench moves on
      t_pl   = exp_pl;
      t_int  = exp_int;
      t_wake = exp_wake;
      t_mdl  = use_model;
      for (int n = 0; n < 10 && !hit; n++) begin
         @(negedge clk);
         if (t_mdl) begin
            model_outputs();
         end else begin
            want_id   = t_id;
            want_pl   = t_pl;
            want_int  = t_int;
            want_wake = t_wake;
         end
         hit = outputs_match();
      end
      if (!hit) begin
         $display("Timeout at %0t: outputs did not settle within 10 cycles", $time);
         if (claimid !== want_id)      report_value("claimid", 32'(want_id), 32'(claimid));
         if (pl !== want_pl)           report_value("pl", 32'(want_pl), 32'(pl));
         if (mexintpend !== want_int)  report_value("mexintpend", 32'(want_int), 32'(mexintpend));
         if (mhwakeup !== want_wake)   report_value("mhwakeup", 32'(want_wake), 32'(mhwakeup));
      end
   endtask

   initial begin
      err_count = 0;
      done_cnt  = 0;
      forever begin
         @(posedge clk);
         if (check_rd) begin
            lat_rd = exp_rd;
            @(negedge clk);   // Data valid until the next edge
            if (rd_data !== lat_rd) report_value("rd_data", lat_rd, rd_data);
         end else if (check_out) begin
            poll_outputs();
            done_cnt++;
         end
      end
   end

endmodule

// File: tb_pic.sv
`timescale 1ns/1ps

module tb_pic;

   localparam int             NUM_SRC = 15;
   localparam pic_pkg::word_t BASE    = 32'hF00C_0000;
   localparam int OP_WR   = 0;
   localparam int OP_RD   = 1;
   localparam int OP_REQ  = 2;
   localparam int OP_WAIT = 3;

   typedef struct {
      int               op;
      pic_pkg::word_t   addr;
      pic_pkg::word_t   data;   // Write data or expected read data
      logic [NUM_SRC:0] req;
      pic_pkg::prio_t   cur;
      pic_pkg::prio_t   pt;
      logic             mdl;
      pic_pkg::id_t     id;
      pic_pkg::prio_t   pl;
      logic             ip;
      logic             wk;
   } row_t;

   logic             clk;
   logic             rst_n;
   pic_pkg::word_t   rd_addr, wr_addr, wr_data, rd_data, exp_rd;
   logic             wren, rden, mexintpend, mhwakeup;
   logic [NUM_SRC:0] extintsrc_req;
   pic_pkg::prio_t   meicurpl, meipt, pl, exp_pl;
   pic_pkg::id_t     claimid, exp_id;
   logic             check_rd, check_out, use_model, exp_int, exp_wake;
   int               err_count, done_cnt, tb_errors, start_cnt, n;
   logic [31:0]      lcg_state;
   row_t             rows [$];
   row_t             row;

   tb_clkgen #(.PERIOD(100.0)) u_clk (.clk(clk));

   pic_top #(.NUM_SRC(NUM_SRC), .PIC_BASE_ADDR(BASE)) uut (
      .clk(clk), .rst_n(rst_n), .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_data(wr_data),
      .wren(wren), .rden(rden), .extintsrc_req(extintsrc_req), .meicurpl(meicurpl),
      .meipt(meipt), .rd_data(rd_data), .mexintpend(mexintpend), .claimid(claimid),
      .pl(pl), .mhwakeup(mhwakeup)
   );

   tb_pic_monitor #(.NUM_SRC(NUM_SRC), .PIC_BASE_ADDR(BASE)) u_mon (
      .clk(clk), .rst_n(rst_n), .wren(wren), .wr_addr(wr_addr), .wr_data(wr_data),
      .extintsrc_req(extintsrc_req), .meicurpl(meicurpl), .meipt(meipt),
      .rd_data(rd_data), .mexintpend(mexintpend), .claimid(claimid), .pl(pl),
      .mhwakeup(mhwakeup), .check_rd(check_rd), .exp_rd(exp_rd), .check_out(check_out),
      .use_model(use_model), .exp_id(exp_id), .exp_pl(exp_pl), .exp_int(exp_int),
      .exp_wake(exp_wake), .err_count(err_count), .done_cnt(done_cnt)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic pic_pkg::word_t reg_addr(input pic_pkg::word_t ofs, input int idx);
      return BASE + ofs + pic_pkg::word_t'(idx * 4);
   endfunction

   ////////////////////
   // Table building

   function automatic row_t blank_row(input int kind);
      row_t r;
      r = '{op: kind, addr: '0, data: '0, req: '0, cur: '0, pt: '0, mdl: 1'b0,
            id: '0, pl: '0, ip: 1'b0, wk: 1'b0};
      return r;
   endfunction

   task automatic stage_write(input pic_pkg::word_t ofs, input int idx, input pic_pkg::word_t d);
      row_t r;
      r      = blank_row(OP_WR);
      r.addr = reg_addr(ofs, idx);
      r.data = d;
      rows.push_back(r);
   endtask

   task automatic read_back(input pic_pkg::word_t ofs, input int idx, input pic_pkg::word_t d);
      row_t r;
      r      = blank_row(OP_RD);
      r.addr = reg_addr(ofs, idx);
      r.data = d;
      rows.push_back(r);
   endtask

   task automatic set_inputs(input logic [NUM_SRC:0] v, input int cur, input int pt);
      row_t r;
      r     = blank_row(OP_REQ);
      r.req = v;
      r.cur = pic_pkg::prio_t'(cur);
      r.pt  = pic_pkg::prio_t'(pt);
      rows.push_back(r);
   endtask

   task automatic expect_outputs(input int id, input int p, input logic ip, input logic wk);
      row_t r;
      r    = blank_row(OP_WAIT);
      r.id = pic_pkg::id_t'(id);
      r.pl = pic_pkg::prio_t'(p);
      r.ip = ip;
      r.wk = wk;
      rows.push_back(r);
   endtask

   task automatic expect_model();
      row_t r;
      r     = blank_row(OP_WAIT);
      r.mdl = 1'b1;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // Reset state and read-back
      expect_outputs(0, 0, 0, 0);
      stage_write(pic_pkg::PRIO_OFS, 1, 5);
      stage_write(pic_pkg::PRIO_OFS, 2, 9);
      stage_write(pic_pkg::PRIO_OFS, 3, 9);
      stage_write(pic_pkg::PRIO_OFS, 0, 7);   // Id 0 is reserved
      for (int i = 1; i <= 3; i++) stage_write(pic_pkg::ENABLE_OFS, i, 1);
      stage_write(pic_pkg::GWCFG_OFS, 4, 3);
      stage_write(pic_pkg::CONFIG_OFS, 0, 1);
      read_back(pic_pkg::PRIO_OFS, 1, 5);
      read_back(pic_pkg::PRIO_OFS, 2, 9);
      read_back(pic_pkg::PRIO_OFS, 0, 0);
      read_back(pic_pkg::ENABLE_OFS, 2, 1);
      read_back(pic_pkg::GWCFG_OFS, 4, 3);
      read_back(pic_pkg::CONFIG_OFS, 0, 1);
      stage_write(pic_pkg::CONFIG_OFS, 0, 0);
      stage_write(pic_pkg::GWCFG_OFS, 4, 0);
      read_back(pic_pkg::CONFIG_OFS, 0, 0);
      // Level sources where a tie goes to the lower id
      set_inputs(16'h000E, 0, 0);
      expect_outputs(2, 9, 1, 0);
      read_back(pic_pkg::PEND_OFS, 0, 32'h0E);
      set_inputs(16'h000A, 0, 0);
      expect_outputs(3, 9, 1, 0);
      stage_write(pic_pkg::GWCFG_OFS, 3, 1);   // Input now inactive
      expect_outputs(1, 5, 1, 0);
      read_back(pic_pkg::PEND_OFS, 0, 32'h02);
      stage_write(pic_pkg::GWCFG_OFS, 3, 0);
      // Threshold and current level
      expect_outputs(3, 9, 1, 0);
      set_inputs(16'h000A, 0, 9);
      expect_outputs(3, 9, 0, 0);
      set_inputs(16'h000A, 9, 8);
      expect_outputs(3, 9, 0, 0);
      set_inputs(16'h000A, 8, 8);
      expect_outputs(3, 9, 1, 0);
      stage_write(pic_pkg::PRIO_OFS, 3, 15);
      expect_outputs(3, 15, 1, 1);
      stage_write(pic_pkg::PRIO_OFS, 3, 9);
      // Edge source 5 with a one-cycle pulse
      stage_write(pic_pkg::PRIO_OFS, 5, 12);
      stage_write(pic_pkg::ENABLE_OFS, 5, 1);
      stage_write(pic_pkg::GWCFG_OFS, 5, 2);
      set_inputs(16'h002A, 0, 0);
      set_inputs(16'h000A, 0, 0);
      expect_outputs(5, 12, 1, 0);
      read_back(pic_pkg::PEND_OFS, 0, 32'h2A);
      stage_write(pic_pkg::GWCLR_OFS, 5, 1);
      expect_outputs(3, 9, 1, 0);
      read_back(pic_pkg::PEND_OFS, 0, 32'h0A);
      // Reversed order with random priorities
      stage_write(pic_pkg::CONFIG_OFS, 0, 1);
      stage_write(pic_pkg::GWCFG_OFS, 5, 0);
      stage_write(pic_pkg::ENABLE_OFS, 4, 1);
      stage_write(pic_pkg::ENABLE_OFS, 6, 1);
      set_inputs(16'h007E, 15, 15);
      for (int round = 0; round < 3; round++) begin
         for (int i = 1; i <= 6; i++) begin
            lcg_state = lcg_step(lcg_state);
            stage_write(pic_pkg::PRIO_OFS, i, pic_pkg::word_t'(lcg_state[19:16]));
         end
         expect_model();
      end
      stage_write(pic_pkg::PRIO_OFS, 1, 0);   // Top level in reversed order
      expect_outputs(1, 0, 1, 1);
   endtask

   ////////////////////
   // Stimulus

   initial begin
      rst_n         = 1'b0;
      rd_addr       = '0;
      wr_addr       = '0;
      wr_data       = '0;
      wren          = 1'b0;
      rden          = 1'b0;
      extintsrc_req = '0;
      meicurpl      = '0;
      meipt         = '0;
      check_rd      = 1'b0;
      check_out     = 1'b0;
      use_model     = 1'b0;
      exp_rd        = '0;
      exp_id        = '0;
      exp_pl        = '0;
      exp_int       = 1'b0;
      exp_wake      = 1'b0;
      tb_errors     = 0;
      lcg_state     = 32'd45208;
      build_table();

      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      for (int r = 0; r < rows.size(); r++) begin
         row = rows[r];
         start_cnt = done_cnt;
         case (row.op)
            OP_WR: begin
               wren    = 1'b1;
               wr_addr = row.addr;
               wr_data = row.data;
            end
            OP_RD: begin
               rden     = 1'b1;
               rd_addr  = row.addr;
               exp_rd   = row.data;
               check_rd = 1'b1;
            end
            OP_REQ: begin
               extintsrc_req = row.req;
               meicurpl      = row.cur;
               meipt         = row.pt;
            end
            default: begin
               use_model = row.mdl;
               exp_id    = row.id;
               exp_pl    = row.pl;
               exp_int   = row.ip;
               exp_wake  = row.wk;
               check_out = 1'b1;
            end
         endcase
         @(negedge clk);
         wren      = 1'b0;
         rden      = 1'b0;
         check_rd  = 1'b0;
         check_out = 1'b0;
         if (row.op == OP_WAIT) begin
            n = 0;
            while (done_cnt == start_cnt && n < 20) begin
               @(posedge clk);
               n++;
            end
            if (done_cnt == start_cnt) begin
               $display("Monitor never finished the output check of row %0d", r);
               tb_errors++;
               break;
            end
            @(negedge clk);
         end
      end

      repeat (2) @(negedge clk);
      $display("Errors: monitor %0d, testbench %0d", err_count, tb_errors);
      if (err_count == 0 && tb_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: vlog.f
pic_pkg.sv
pic_gateway.sv
pic_regs.sv
pic_arbiter.sv
pic_notify.sv
pic_top.sv
pic_chk.sv
tb_clkgen.sv
tb_pic_monitor.sv
tb_pic.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_pic
FILELIST = vlog.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
